/* design/dpram_cfg.svh */
// Configuration macros for the dual-port RAM: data width, word address width, latency, buffer depth
`ifndef DPRAM_CFG_SVH
`define DPRAM_CFG_SVH

// Data word width in bits
`define DPRAM_DATA_W 32

// Word address width, 512 words
`define DPRAM_ADDR_W 9

// Extra output pipeline stages after the array read register
`define DPRAM_LATENCY 3

// Response buffer entries per port, also the credit limit of each front
`define DPRAM_RSP_DEPTH 8

`endif

/* design/axil_pkg.sv */
// AXI4-Lite channel payload structs and response code
`include "dpram_cfg.svh"

package axil_pkg;

    // Response code, only OKAY is produced by this design
    typedef enum logic [1:0] {
        AXIL_OKAY   = 2'b00,
        AXIL_EXOKAY = 2'b01,
        AXIL_SLVERR = 2'b10,
        AXIL_DECERR = 2'b11
    } axil_resp_e;

    // Write address channel, byte address
    typedef struct packed {
        logic [31:0] addr;
    } axil_aw_t;

    // Write data channel
    typedef struct packed {
        logic [`DPRAM_DATA_W-1:0]   data;
        logic [`DPRAM_DATA_W/8-1:0] strb;
    } axil_w_t;

    // Read address channel, byte address
    typedef struct packed {
        logic [31:0] addr;
    } axil_ar_t;

    // Write response channel
    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // Read data channel
    typedef struct packed {
        logic [`DPRAM_DATA_W-1:0] data;
        axil_resp_e               resp;
    } axil_r_t;

endpackage

/* design/dpram_pkg.sv */
// Memory request and memory result structs of the RAM path
`include "dpram_cfg.svh"

package dpram_pkg;

    // One request from a front into the RAM
    typedef struct packed {
        logic                       valid;
        logic                       is_write;
        logic [`DPRAM_ADDR_W-1:0]   addr;
        logic [`DPRAM_DATA_W-1:0]   data;
        logic [`DPRAM_DATA_W/8-1:0] strb;
    } mem_req_t;

    // One result from the RAM, writes come back with is_write set
    typedef struct packed {
        logic                     is_write;
        logic [`DPRAM_DATA_W-1:0] data;
    } mem_rsp_t;

endpackage

/* design/latency_pipe.sv */
// Valid-tagged fixed-length delay line with a type parameter for the payload
`timescale 1ns/1ps

module latency_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] vld_q;
    payload_t         data_q [DEPTH];

    // Valid chain
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Payload chain
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = vld_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

/* design/axil_req_front.sv */
// AXI4-Lite slave request front: write/read arbitration, credit counter and memory request register
`timescale 1ns/1ps
`include "dpram_cfg.svh"

module axil_req_front (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  axil_pkg::axil_aw_t  aw,
    input  logic                w_valid,
    output logic                w_ready,
    input  axil_pkg::axil_w_t   w,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  axil_pkg::axil_ar_t  ar,
    input  logic                slot_free,
    output dpram_pkg::mem_req_t req
);

    localparam int CNT_W = $clog2(`DPRAM_RSP_DEPTH + 1);

    logic                       prefer_wr_q;
    logic [CNT_W-1:0]           outstanding;
    logic                       credit;
    logic                       wr_pend;
    logic                       rd_pend;
    logic                       wr_fire;
    logic                       rd_fire;
    logic                       req_valid_q;
    logic                       req_write_q;
    logic [`DPRAM_ADDR_W-1:0]   req_addr_q;
    logic [`DPRAM_DATA_W-1:0]   req_data_q;
    logic [`DPRAM_DATA_W/8-1:0] req_strb_q;

    assign credit  = (outstanding < CNT_W'(`DPRAM_RSP_DEPTH));
    assign wr_pend = aw_valid & w_valid;
    assign rd_pend = ar_valid;

    // A write needs both aw and w, so neither is taken alone
    assign aw_ready = credit & (prefer_wr_q | ~rd_pend) & (w_valid | ~aw_valid);
    assign w_ready  = credit & (prefer_wr_q | ~rd_pend) & (aw_valid | ~w_valid);
    assign ar_ready = credit & (~prefer_wr_q | ~wr_pend);

    assign wr_fire = wr_pend & aw_ready;
    assign rd_fire = rd_pend & ar_ready;

    // Alternation state and outstanding count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prefer_wr_q <= 1'b1;
            outstanding <= '0;
            req_valid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                prefer_wr_q <= 1'b0;
            end else if (rd_fire) begin
                prefer_wr_q <= 1'b1;
            end
            case ({wr_fire | rd_fire, slot_free})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
            req_valid_q <= wr_fire | rd_fire;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            req_write_q <= 1'b1;
            req_addr_q  <= aw.addr[`DPRAM_ADDR_W+1:2];
            req_data_q  <= w.data;
            req_strb_q  <= w.strb;
        end else if (rd_fire) begin
            req_write_q <= 1'b0;
            req_addr_q  <= ar.addr[`DPRAM_ADDR_W+1:2];
        end
    end

    always_comb begin
        req.valid    = req_valid_q;
        req.is_write = req_write_q;
        req.addr     = req_addr_q;
        req.data     = req_data_q;
        req.strb     = req_strb_q;
    end

endmodule

/* design/tdp_ram_latency_match.sv */
// True dual-port RAM with two request stages, byte strobes, collision rule and matched latency
`timescale 1ns/1ps
`include "dpram_cfg.svh"

module tdp_ram_latency_match (
    input  logic                clk,
    input  logic                arst_n,
    input  dpram_pkg::mem_req_t m_req,
    input  dpram_pkg::mem_req_t n_req,
    output logic                m_rsp_valid,
    output dpram_pkg::mem_rsp_t m_rsp,
    output logic                n_rsp_valid,
    output dpram_pkg::mem_rsp_t n_rsp
);

    localparam int STRB_W = `DPRAM_DATA_W / 8;

    // Index 0 is port m, index 1 is port n
    logic [`DPRAM_DATA_W-1:0] mem [0:(1 << `DPRAM_ADDR_W)-1];
    logic [1:0]               s0_valid;
    logic [1:0]               s1_valid;
    dpram_pkg::mem_req_t      s0_req [2];
    dpram_pkg::mem_req_t      s1_req [2];
    logic [1:0]               wr_en;
    logic [1:0]               rd_valid_q;
    dpram_pkg::mem_rsp_t      rd_rsp_q [2];

    // Request stage valids
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s0_valid   <= '0;
            s1_valid   <= '0;
            rd_valid_q <= '0;
        end else begin
            s0_valid   <= {n_req.valid, m_req.valid};
            s1_valid   <= s0_valid;
            rd_valid_q <= s1_valid;
        end
    end

    // Address, write data and strobes travel together
    always_ff @(posedge clk) begin
        s0_req[0] <= m_req;
        s0_req[1] <= n_req;
        s1_req    <= s0_req;
    end

    assign wr_en[0] = s1_valid[0] & s1_req[0].is_write;
    assign wr_en[1] = s1_valid[1] & s1_req[1].is_write;

    // Array access, the read sees the word as it was before this cycle's writes
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            rd_rsp_q[p].is_write <= s1_req[p].is_write;
            rd_rsp_q[p].data     <= mem[s1_req[p].addr];
        end
        // Port n goes first so that port m's strobed bytes win a collision
        for (int p = 1; p >= 0; p--) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_en[p] && s1_req[p].strb[b]) begin
                    mem[s1_req[p].addr][8*b +: 8] <= s1_req[p].data[8*b +: 8];
                end
            end
        end
    end

    latency_pipe #(
        .payload_t (dpram_pkg::mem_rsp_t),
        .DEPTH     (`DPRAM_LATENCY)
    ) u_m_pipe (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (rd_valid_q[0]),
        .in_data   (rd_rsp_q[0]),
        .out_valid (m_rsp_valid),
        .out_data  (m_rsp)
    );

    latency_pipe #(
        .payload_t (dpram_pkg::mem_rsp_t),
        .DEPTH     (`DPRAM_LATENCY)
    ) u_n_pipe (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (rd_valid_q[1]),
        .in_data   (rd_rsp_q[1]),
        .out_valid (n_rsp_valid),
        .out_data  (n_rsp)
    );

endmodule

/* design/axil_resp_buffer.sv */
// Response FIFO that returns memory results as AXI4-Lite B or R beats and frees credits
`timescale 1ns/1ps
`include "dpram_cfg.svh"

module axil_resp_buffer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rsp_valid,
    input  dpram_pkg::mem_rsp_t rsp,
    output logic                b_valid,
    input  logic                b_ready,
    output axil_pkg::axil_b_t   b,
    output logic                r_valid,
    input  logic                r_ready,
    output axil_pkg::axil_r_t   r,
    output logic                slot_free
);

    localparam int DEPTH = `DPRAM_RSP_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dpram_pkg::mem_rsp_t fifo_q [DEPTH];
    dpram_pkg::mem_rsp_t head;
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                not_empty;
    logic                pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head      = fifo_q[rd_ptr_q];
    assign not_empty = (count_q != '0);

    // Head goes to B for a write result and to R for a read result
    assign b_valid = not_empty & head.is_write;
    assign r_valid = not_empty & ~head.is_write;
    assign b.resp  = axil_pkg::AXIL_OKAY;
    assign r.data  = head.data;
    assign r.resp  = axil_pkg::AXIL_OKAY;

    assign pop       = (b_valid & b_ready) | (r_valid & r_ready);
    assign slot_free = pop;

    // Pointers and fill level, the credit scheme keeps pushes away from a full FIFO
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (rsp_valid) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop)       rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({rsp_valid, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            fifo_q[wr_ptr_q] <= rsp;
        end
    end

endmodule

/* design/dual_axil_ram_top.sv */
// Top level with two AXI4-Lite fronts, the shared dual-port RAM and two response buffers
`timescale 1ns/1ps
`include "dpram_cfg.svh"

module dual_axil_ram_top (
    input  logic               clk,
    input  logic               arst_n,
    // Port m
    input  logic               m_aw_valid,
    output logic               m_aw_ready,
    input  axil_pkg::axil_aw_t m_aw,
    input  logic               m_w_valid,
    output logic               m_w_ready,
    input  axil_pkg::axil_w_t  m_w,
    input  logic               m_ar_valid,
    output logic               m_ar_ready,
    input  axil_pkg::axil_ar_t m_ar,
    output logic               m_b_valid,
    input  logic               m_b_ready,
    output axil_pkg::axil_b_t  m_b,
    output logic               m_r_valid,
    input  logic               m_r_ready,
    output axil_pkg::axil_r_t  m_r,
    // Port n
    input  logic               n_aw_valid,
    output logic               n_aw_ready,
    input  axil_pkg::axil_aw_t n_aw,
    input  logic               n_w_valid,
    output logic               n_w_ready,
    input  axil_pkg::axil_w_t  n_w,
    input  logic               n_ar_valid,
    output logic               n_ar_ready,
    input  axil_pkg::axil_ar_t n_ar,
    output logic               n_b_valid,
    input  logic               n_b_ready,
    output axil_pkg::axil_b_t  n_b,
    output logic               n_r_valid,
    input  logic               n_r_ready,
    output axil_pkg::axil_r_t  n_r
);

    dpram_pkg::mem_req_t m_req;
    dpram_pkg::mem_req_t n_req;
    dpram_pkg::mem_rsp_t m_rsp;
    dpram_pkg::mem_rsp_t n_rsp;
    logic                m_rsp_valid;
    logic                n_rsp_valid;
    logic                m_slot_free;
    logic                n_slot_free;

    axil_req_front u_m_front (
        .clk       (clk),
        .arst_n    (arst_n),
        .aw_valid  (m_aw_valid),
        .aw_ready  (m_aw_ready),
        .aw        (m_aw),
        .w_valid   (m_w_valid),
        .w_ready   (m_w_ready),
        .w         (m_w),
        .ar_valid  (m_ar_valid),
        .ar_ready  (m_ar_ready),
        .ar        (m_ar),
        .slot_free (m_slot_free),
        .req       (m_req)
    );

    axil_req_front u_n_front (
        .clk       (clk),
        .arst_n    (arst_n),
        .aw_valid  (n_aw_valid),
        .aw_ready  (n_aw_ready),
        .aw        (n_aw),
        .w_valid   (n_w_valid),
        .w_ready   (n_w_ready),
        .w         (n_w),
        .ar_valid  (n_ar_valid),
        .ar_ready  (n_ar_ready),
        .ar        (n_ar),
        .slot_free (n_slot_free),
        .req       (n_req)
    );

    tdp_ram_latency_match u_ram (
        .clk         (clk),
        .arst_n      (arst_n),
        .m_req       (m_req),
        .n_req       (n_req),
        .m_rsp_valid (m_rsp_valid),
        .m_rsp       (m_rsp),
        .n_rsp_valid (n_rsp_valid),
        .n_rsp       (n_rsp)
    );

    axil_resp_buffer u_m_rsp (
        .clk       (clk),
        .arst_n    (arst_n),
        .rsp_valid (m_rsp_valid),
        .rsp       (m_rsp),
        .b_valid   (m_b_valid),
        .b_ready   (m_b_ready),
        .b         (m_b),
        .r_valid   (m_r_valid),
        .r_ready   (m_r_ready),
        .r         (m_r),
        .slot_free (m_slot_free)
    );

    axil_resp_buffer u_n_rsp (
        .clk       (clk),
        .arst_n    (arst_n),
        .rsp_valid (n_rsp_valid),
        .rsp       (n_rsp),
        .b_valid   (n_b_valid),
        .b_ready   (n_b_ready),
        .b         (n_b),
        .r_valid   (n_r_valid),
        .r_ready   (n_r_ready),
        .r         (n_r),
        .slot_free (n_slot_free)
    );

endmodule

/* verif/ram_properties.sv */
// Bound assertions on the AXI4-Lite B and R channels and the credit counters
`timescale 1ns/1ps
`include "dpram_cfg.svh"

module ram_properties (
    input logic                                       clk,
    input logic                                       arst_n,
    input logic                                       m_b_valid,
    input logic                                       m_b_ready,
    input axil_pkg::axil_b_t                          m_b,
    input logic                                       m_r_valid,
    input logic                                       m_r_ready,
    input axil_pkg::axil_r_t                          m_r,
    input logic                                       n_b_valid,
    input logic                                       n_b_ready,
    input axil_pkg::axil_b_t                          n_b,
    input logic                                       n_r_valid,
    input logic                                       n_r_ready,
    input axil_pkg::axil_r_t                          n_r,
    input logic [$clog2(`DPRAM_RSP_DEPTH + 1)-1:0]    m_outstanding,
    input logic [$clog2(`DPRAM_RSP_DEPTH + 1)-1:0]    n_outstanding
);

    // A beat holds valid and payload until it is taken
    a_m_b_hold : assert property (@(posedge clk) disable iff (!arst_n)
        m_b_valid && !m_b_ready |=> m_b_valid && $stable(m_b))
        else $error("Port m B beat dropped or changed before ready");
    a_m_r_hold : assert property (@(posedge clk) disable iff (!arst_n)
        m_r_valid && !m_r_ready |=> m_r_valid && $stable(m_r))
        else $error("Port m R beat dropped or changed before ready");
    a_n_b_hold : assert property (@(posedge clk) disable iff (!arst_n)
        n_b_valid && !n_b_ready |=> n_b_valid && $stable(n_b))
        else $error("Port n B beat dropped or changed before ready");
    a_n_r_hold : assert property (@(posedge clk) disable iff (!arst_n)
        n_r_valid && !n_r_ready |=> n_r_valid && $stable(n_r))
        else $error("Port n R beat dropped or changed before ready");

    // First cycle out of reset
    a_rst_quiet : assert property (@(posedge clk)
        $rose(arst_n) |-> !m_b_valid && !m_r_valid && !n_b_valid && !n_r_valid)
        else $error("Response valid high in the cycle after reset");

    a_credit : assert property (@(posedge clk) disable iff (!arst_n)
        m_outstanding <= `DPRAM_RSP_DEPTH && n_outstanding <= `DPRAM_RSP_DEPTH)
        else $error("Outstanding count above the response buffer depth");

endmodule

bind dual_axil_ram_top ram_properties u_props (
    .clk           (clk),
    .arst_n        (arst_n),
    .m_b_valid     (m_b_valid),
    .m_b_ready     (m_b_ready),
    .m_b           (m_b),
    .m_r_valid     (m_r_valid),
    .m_r_ready     (m_r_ready),
    .m_r           (m_r),
    .n_b_valid     (n_b_valid),
    .n_b_ready     (n_b_ready),
    .n_b           (n_b),
    .n_r_valid     (n_r_valid),
    .n_r_ready     (n_r_ready),
    .n_r           (n_r),
    .m_outstanding (u_m_front.outstanding),
    .n_outstanding (u_n_front.outstanding)
);

/* verif/ram_checker.sv */
// Response checker with expectation queues, per-test result lines and the run summary
`timescale 1ns/1ps

module ram_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [1:0]              b_valid,
    input  logic [1:0]              b_ready,
    input  axil_pkg::axil_b_t [1:0] b,
    input  logic [1:0]              r_valid,
    input  logic [1:0]              r_ready,
    input  axil_pkg::axil_r_t [1:0] r,
    input  logic [1:0]              exp_push,
    input  logic [1:0]              exp_write,
    input  logic [1:0][31:0]        exp_data,
    input  logic                    test_end,
    input  logic [127:0]            test_name,
    input  logic                    run_end,
    output logic                    idle,
    output int                      error_count
);

    // Bit 32 marks a write and the low word holds the expected read data
    logic [32:0] exp_q [2][$];
    logic        empty_q    = 1'b1;
    int          total_err  = 0;
    int          test_err   = 0;
    int          test_chk   = 0;
    int          total_chk  = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;

    assign idle        = empty_q;
    assign error_count = total_err;

    task automatic check_resp(input int p, input logic is_wr, input logic [31:0] data,
                              input logic [1:0] resp);
        logic [32:0] e;
        test_chk++;
        total_chk++;
        if (exp_q[p].size() == 0) begin
            $display("Port %s returned a response that was never requested", p == 0 ? "m" : "n");
            test_err++;
            total_err++;
        end else begin
            e = exp_q[p].pop_front();
            if (e[32] != is_wr) begin
                $display("Mismatch at %0t: port %s expected a %s response", $time,
                         p == 0 ? "m" : "n", e[32] ? "B" : "R");
                test_err++;
                total_err++;
            end else if (!is_wr && data !== e[31:0]) begin
                $display("Mismatch at %0t: port %s read data %h, expected %h", $time,
                         p == 0 ? "m" : "n", data, e[31:0]);
                test_err++;
                total_err++;
            end
            if (resp !== 2'b00) begin
                $display("Mismatch at %0t: port %s resp %b, expected OKAY", $time,
                         p == 0 ? "m" : "n", resp);
                test_err++;
                total_err++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < 2; p++) begin
                if (b_valid[p] && b_ready[p]) check_resp(p, 1'b1, '0, b[p].resp);
                if (r_valid[p] && r_ready[p]) check_resp(p, 1'b0, r[p].data, r[p].resp);
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (exp_push[p]) exp_q[p].push_back({exp_write[p], exp_data[p]});
        end
        empty_q = (exp_q[0].size() == 0) && (exp_q[1].size() == 0);
        if (test_end) begin
            if (test_err == 0) begin
                $display("Test %0s: PASS (%0d checks)", test_name, test_chk);
                tests_pass++;
            end else begin
                $display("Test %0s: FAIL (%0d errors)", test_name, test_err);
                tests_fail++;
            end
            test_err = 0;
            test_chk = 0;
        end
        if (run_end) begin
            $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                     tests_pass, tests_fail, total_chk, total_err);
        end
    end

endmodule

/* verif/tb_top.sv */
// Testbench top: clock, reset, trace-driven stimulus on both ports and random ready back-pressure
`timescale 1ns/1ps

module tb_top;

    localparam int TIMEOUT = 200;

    logic                     clk;
    logic                     arst_n;
    logic [1:0]               aw_valid;
    logic [1:0]               aw_ready;
    axil_pkg::axil_aw_t [1:0] aw;
    logic [1:0]               w_valid;
    logic [1:0]               w_ready;
    axil_pkg::axil_w_t [1:0]  w;
    logic [1:0]               ar_valid;
    logic [1:0]               ar_ready;
    axil_pkg::axil_ar_t [1:0] ar;
    logic [1:0]               b_valid;
    logic [1:0]               b_ready;
    axil_pkg::axil_b_t [1:0]  b;
    logic [1:0]               r_valid;
    logic [1:0]               r_ready;
    axil_pkg::axil_r_t [1:0]  r;
    logic [1:0]               exp_push;
    logic [1:0]               exp_write;
    logic [1:0][31:0]         exp_data;
    logic                     test_end;
    logic [127:0]             test_name;
    logic                     run_end;
    logic                     chk_idle;
    int                       error_count;
    logic                     failed;

    dual_axil_ram_top u_dual_axil_ram_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .m_aw_valid (aw_valid[0]),
        .m_aw_ready (aw_ready[0]),
        .m_aw       (aw[0]),
        .m_w_valid  (w_valid[0]),
        .m_w_ready  (w_ready[0]),
        .m_w        (w[0]),
        .m_ar_valid (ar_valid[0]),
        .m_ar_ready (ar_ready[0]),
        .m_ar       (ar[0]),
        .m_b_valid  (b_valid[0]),
        .m_b_ready  (b_ready[0]),
        .m_b        (b[0]),
        .m_r_valid  (r_valid[0]),
        .m_r_ready  (r_ready[0]),
        .m_r        (r[0]),
        .n_aw_valid (aw_valid[1]),
        .n_aw_ready (aw_ready[1]),
        .n_aw       (aw[1]),
        .n_w_valid  (w_valid[1]),
        .n_w_ready  (w_ready[1]),
        .n_w        (w[1]),
        .n_ar_valid (ar_valid[1]),
        .n_ar_ready (ar_ready[1]),
        .n_ar       (ar[1]),
        .n_b_valid  (b_valid[1]),
        .n_b_ready  (b_ready[1]),
        .n_b        (b[1]),
        .n_r_valid  (r_valid[1]),
        .n_r_ready  (r_ready[1]),
        .n_r        (r[1])
    );

    ram_checker u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b           (b),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .exp_push    (exp_push),
        .exp_write   (exp_write),
        .exp_data    (exp_data),
        .test_end    (test_end),
        .test_name   (test_name),
        .run_end     (run_end),
        .idle        (chk_idle),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Random ready back-pressure on B and R
    initial begin
        void'($urandom(40075));
        forever begin
            @(posedge clk);
            #2;
            b_ready = {$urandom % 4 != 0, $urandom % 4 != 0};
            r_ready = {$urandom % 4 != 0, $urandom % 4 != 0};
        end
    end

    // One transaction on one port, ends 2 ns after the accepting edge
    task automatic issue(input int p, input int op, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] strb,
                         input logic [31:0] exp);
        int cnt;
        cnt = 0;
        if (op == 1) begin
            ar[p].addr  = addr;
            ar_valid[p] = 1'b1;
        end else if (op == 2) begin
            aw[p].addr  = addr;
            w[p].data   = data;
            w[p].strb   = strb;
            aw_valid[p] = 1'b1;
            w_valid[p]  = 1'b1;
        end else begin
            return;
        end
        @(negedge clk);
        while (!(op == 1 ? ar_ready[p] : (aw_ready[p] && w_ready[p])) && !failed) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Timeout: port %s request was never accepted", p == 0 ? "m" : "n");
                failed = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        exp_push[p]  = !failed;
        exp_write[p] = (op == 2);
        exp_data[p]  = exp;
        @(posedge clk);
        #2;
        ar_valid[p] = 1'b0;
        aw_valid[p] = 1'b0;
        w_valid[p]  = 1'b0;
        exp_push[p] = 1'b0;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!chk_idle && !failed) begin
            cnt++;
            if (cnt > TIMEOUT) begin
                $display("Timeout: not every expected response came back");
                failed = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic finish_test(input logic [127:0] nm);
        wait_drain();
        if (!failed) begin
            test_name = nm;
            test_end  = 1'b1;
            @(posedge clk);
            #2;
            test_end = 1'b0;
        end
    endtask

    initial begin
        int               fd;
        int               got;
        int               m_op;
        int               n_op;
        logic [8*200-1:0] line;
        logic [127:0]     name;
        logic [127:0]     cur;
        logic [31:0]      m_addr, m_data, m_exp;
        logic [31:0]      n_addr, n_data, n_exp;
        logic [3:0]       m_strb, n_strb;
        aw_valid  = '0;
        w_valid   = '0;
        ar_valid  = '0;
        aw        = '0;
        w         = '0;
        ar        = '0;
        b_ready   = '1;
        r_ready   = '1;
        exp_push  = '0;
        exp_write = '0;
        exp_data  = '0;
        test_end  = 1'b0;
        test_name = '0;
        run_end   = 1'b0;
        failed    = 1'b0;
        cur       = '0;
        arst_n    = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        fd = $fopen("verif/ram_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verif/ram_trace.txt");
            failed = 1'b1;
        end
        while (!failed && !$feof(fd)) begin
            got = $fgets(line, fd);
            if (got != 0 && $sscanf(line, "%s %d %h %h %h %d %h %h %h %h %h", name, m_op,
                    m_addr, m_data, m_strb, n_op, n_addr, n_data, n_strb, m_exp, n_exp) == 11) begin
                if (name != cur) begin
                    if (cur != '0) finish_test(cur);
                    cur = name;
                end
                if (m_op == 3) begin
                    wait_drain();
                    apply_reset();
                end else if (!failed) begin
                    fork
                        issue(0, m_op, m_addr, m_data, m_strb, m_exp);
                        issue(1, n_op, n_addr, n_data, n_strb, n_exp);
                    join
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (!failed && cur != '0) finish_test(cur);
        @(negedge clk);
        run_end = 1'b1;
        @(posedge clk);
        #2;
        run_end = 1'b0;
        @(negedge clk);
        if (failed || error_count != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

/* verif/ram_trace.txt */
# name m_op m_addr m_data m_strb n_op n_addr n_data n_strb m_exp n_exp
# op codes 0 idle 1 read 2 write 3 reset
wr_then_rd 2 00000010 11223344 f 0 0 0 0 0 0
wr_then_rd 0 0 0 0 1 00000010 0 0 0 11223344
strobe_merge 2 00000020 aabbccdd f 0 0 0 0 0 0
strobe_merge 2 00000020 11223344 5 0 0 0 0 0 0
strobe_merge 1 00000020 0 0 0 0 0 0 aa22cc44 0
collision 2 00000040 11111111 3 2 00000040 22222222 f 0 0
collision 1 00000040 0 0 1 00000040 0 0 22221111 22221111
burst_read 1 00000010 0 0 0 0 0 0 11223344 0
burst_read 1 00000020 0 0 0 0 0 0 aa22cc44 0
burst_read 1 00000040 0 0 0 0 0 0 22221111 0
burst_read 1 00000010 0 0 0 0 0 0 11223344 0
burst_read 1 00000020 0 0 0 0 0 0 aa22cc44 0
burst_read 1 00000040 0 0 0 0 0 0 22221111 0
burst_read 1 00000010 0 0 0 0 0 0 11223344 0
burst_read 1 00000020 0 0 0 0 0 0 aa22cc44 0
burst_read 1 00000040 0 0 0 0 0 0 22221111 0
burst_read 1 00000010 0 0 0 0 0 0 11223344 0
mixed_order 2 00000080 cafef00d f 0 0 0 0 0 0
mixed_order 1 00000080 0 0 0 0 0 0 cafef00d 0
mixed_order 2 00000084 12345678 f 0 0 0 0 0 0
mixed_order 1 00000010 0 0 0 0 0 0 11223344 0
mixed_order 1 00000084 0 0 0 0 0 0 12345678 0
reset_keep 3 0 0 0 0 0 0 0 0 0
reset_keep 1 00000080 0 0 1 00000084 0 0 cafef00d 12345678

/* sources.f */
+incdir+design
design/axil_pkg.sv
design/dpram_pkg.sv
design/latency_pipe.sv
design/axil_req_front.sv
design/tdp_ram_latency_match.sv
design/axil_resp_buffer.sv
design/dual_axil_ram_top.sv
verif/ram_properties.sv
verif/ram_checker.sv
verif/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dual-port RAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_top -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
